/* Makefile */
# Verilator flow for the panel and microphone block

VERILATOR ?= verilator
TOP       ?= board_specific_top_tb
RTL_TOP   ?= board_specific_top
FILELIST  ?= board_specific_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$($(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* board_specific_top.f */
logic/panel_cfg_pkg.sv
logic/seg_pkg.sv
logic/i2s_mic_receiver.sv
logic/key_debouncer.sv
logic/level_meter.sv
logic/tm1638_display_driver.sv
logic/board_specific_top.sv
test/board_specific_top_tb.sv

/* logic/board_specific_top.sv */
`timescale 1ns/10ps

module board_specific_top
#(
    parameter clk_mhz         = 125,
              sck_div         = 20,
              sio_div         = 32,
              debounce_cycles = clk_mhz * 2000       // About 2 ms
)
(
    input                                clk,
    input                                rst_n,
    input  [panel_cfg_pkg::w_key - 1:0]  key,        // Active low on the board
    input                                sd,
    output                               sck,
    output                               ws,
    output                               lr,
    output                               sio_clk,
    output                               sio_stb,
    output                               sio_data,
    output [panel_cfg_pkg::w_led - 1:0]  led
);

    import panel_cfg_pkg::*;
    import seg_pkg::*;

    mic_sample_t        sample;
    logic [w_key - 1:0] keys;                        // Debounced, active high
    panel_image_t       image;

    //------------------------------------------------------------------------

    i2s_mic_receiver #(.sck_div (sck_div)) mic_receiver_i
    (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .sd     ( sd     ),
        .sck    ( sck    ),
        .ws     ( ws     ),
        .lr     ( lr     ),
        .sample ( sample )
    );

    generate
        genvar i;

        for (i = 0; i < w_key; i++)
        begin : debounce
            key_debouncer #(.debounce_cycles (debounce_cycles)) key_debouncer_i
            (
                .clk    ( clk      ),
                .rst_n  ( rst_n    ),
                .raw    ( ~key [i] ),
                .stable ( keys [i] )
            );
        end
    endgenerate

    level_meter level_meter_i
    (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .keys   ( keys   ),
        .sample ( sample ),
        .image  ( image  ),
        .led    ( led    )
    );

    tm1638_display_driver #(.sio_div (sio_div)) display_driver_i
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .image    ( image    ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data )
    );

endmodule

/* logic/i2s_mic_receiver.sv */
`timescale 1ns/10ps

module i2s_mic_receiver
#(
    parameter sck_div = 20
)
(
    input                         clk,
    input                         rst_n,
    input                         sd,
    output                        sck,
    output                        ws,
    output                        lr,
    output seg_pkg::mic_sample_t  sample
);

    import panel_cfg_pkg::*;
    import seg_pkg::*;

    localparam int w_div = (sck_div > 1) ? $clog2 (sck_div) : 1;

    logic [w_div - 1:0] div_cnt;
    logic               sck_q;
    logic [        5:0] slot;                    // Counts sck periods with ws in bit 5
    logic [w_mic - 1:0] shift_q;
    logic               word_done;
    logic               toggle;
    logic               sck_rise;
    logic               sck_fall;
    logic               data_bit;

    assign toggle   = (div_cnt == w_div'(sck_div - 1));
    assign sck_rise = toggle & ~sck_q;
    assign sck_fall = toggle &  sck_q;

    // MSB one sck after ws falls and LSB 23 sck periods later
    assign data_bit = ~slot [5] && (slot [4:0] >= 5'd1) && (slot [4:0] <= 5'd24);

    assign sck = sck_q;
    assign ws  = slot [5];                       // Low selects the left slot
    assign lr  = 1'b0;                           // Mic strapped to left

    //------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            div_cnt      <= '0;
            sck_q        <= 1'b0;
            slot         <= 6'd63;               // First fall starts a left slot
            word_done    <= 1'b0;
            sample.valid <= 1'b0;
        end
        else
        begin
            div_cnt <= toggle ? '0 : div_cnt + 1'b1;

            if (toggle)
                sck_q <= ~sck_q;

            if (sck_fall)
                slot <= slot + 1'b1;

            word_done    <= sck_rise && ~slot [5] && (slot [4:0] == 5'd24);
            sample.valid <= word_done;

            if (word_done)
                sample.value <= shift_q;
        end
    end

    always_ff @(posedge clk)
        if (sck_rise && data_bit)
            shift_q <= {shift_q [w_mic - 2:0], sd};

    valid_single_cycle : assert property (
        @(posedge clk) disable iff (!rst_n) sample.valid |=> !sample.valid);

endmodule

/* logic/key_debouncer.sv */
`timescale 1ns/10ps

module key_debouncer
#(
    parameter debounce_cycles = 250000
)
(
    input        clk,
    input        rst_n,
    input        raw,
    output logic stable
);

    localparam int w_cnt = $clog2 (debounce_cycles + 1);

    logic [        1:0] sync_q;                  // Metastability guard
    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sync_q <= 2'b00;
            cnt    <= '0;
            stable <= 1'b0;
        end
        else
        begin
            sync_q <= {sync_q [0], raw};

            if (sync_q [1] == stable)
                cnt <= '0;                       // Any bounce restarts the wait
            else if (cnt == w_cnt'(debounce_cycles - 1))
            begin
                stable <= sync_q [1];
                cnt    <= '0;
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

endmodule

/* logic/level_meter.sv */
`timescale 1ns/10ps

module level_meter
(
    input                                      clk,
    input                                      rst_n,
    input        [panel_cfg_pkg::w_key - 1:0]  keys,
    input  seg_pkg::mic_sample_t               sample,
    output seg_pkg::panel_image_t              image,
    output logic [panel_cfg_pkg::w_led - 1:0]  led
);

    import panel_cfg_pkg::*;
    import seg_pkg::*;

    logic [w_mic - 1:0] peak;
    logic [w_mic - 1:0] peak_next;
    logic [w_mic - 1:0] mag;
    logic               clip;
    logic               clip_next;
    logic               key0_q;
    logic               clear;
    logic               freeze;

    // Six hex digits of the peak and a bar driven by bits 22 to 20
    function automatic panel_image_t build_image (input logic [w_mic - 1:0] p);
        panel_image_t img;
        for (int i = 0; i < w_tm_digit; i++)
            img.digits [i] = (i < 6) ? hex_to_seg (p [i * 4 +: 4]) : seg_blank;
        for (int i = 0; i < w_tm_led; i++)
            img.leds [i] = (p [w_mic - 2 -: 3] > 3'(i));
        return img;
    endfunction

    assign clear  = keys [0] & ~key0_q;          // Press edge only
    assign freeze = keys [1];

    //------------------------------------------------------------------------

    always_comb
    begin
        if (!sample.value [w_mic - 1])
            mag = sample.value;
        else if (sample.value == {1'b1, {(w_mic - 1) {1'b0}}})
            mag = {1'b0, {(w_mic - 1) {1'b1}}};  // -2^23 has no positive twin
        else
            mag = -sample.value;

        peak_next = peak;
        clip_next = clip;

        if (clear)
        begin
            peak_next = '0;
            clip_next = 1'b0;
        end
        else if (sample.valid)
        begin
            if (!freeze && (mag > peak))
                peak_next = mag;
            if (mag >= clip_level)
                clip_next = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            peak   <= '0;
            clip   <= 1'b0;
            key0_q <= 1'b0;
            led    <= '0;
            image  <= build_image ('0);
        end
        else
        begin
            peak   <= peak_next;
            clip   <= clip_next;
            key0_q <= keys [0];
            led    <= {clip_next, freeze};
            image  <= build_image (peak_next);
        end
    end

    peak_monotonic : assert property (
        @(posedge clk) disable iff (!rst_n) !clear |=> peak >= $past (peak));

endmodule

/* logic/panel_cfg_pkg.sv */
package panel_cfg_pkg;

    //------------------------------------------------------------------------
    // Board resources

    localparam int w_key      = 3;   // Push buttons on the board
    localparam int w_led      = 2;   // Discrete LEDs on the board

    //------------------------------------------------------------------------
    // TM1638 front panel

    localparam int w_tm_digit = 8;   // Seven-segment digits
    localparam int w_tm_led   = 8;   // Red LEDs above the digits

    //------------------------------------------------------------------------
    // INMP441 microphone

    localparam int w_mic      = 24;  // Significant bits per I2S slot

    // Anything this loud is treated as clipped
    localparam logic [w_mic - 1:0] clip_level = 24'h7ff000;

endpackage

/* logic/seg_pkg.sv */
package seg_pkg;

    import panel_cfg_pkg::*;

    //------------------------------------------------------------------------
    // Segment and panel types

    typedef logic [7:0] seg_t;               // hgfedcba with h as the point

    typedef struct packed
    {
        seg_t [w_tm_digit - 1:0] digits;     // Digit 0 is the rightmost
        logic [w_tm_led   - 1:0] leds;
    } panel_image_t;

    typedef struct packed
    {
        logic                     valid;     // One clk pulse per word
        logic signed [w_mic - 1:0] value;
    } mic_sample_t;

    localparam seg_t seg_blank = 8'h00;

    //------------------------------------------------------------------------
    // Hex glyphs with lower case b and d to keep them apart from 8 and 0

    function automatic seg_t hex_to_seg (input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'h3f;
            4'h1: return 8'h06;
            4'h2: return 8'h5b;
            4'h3: return 8'h4f;
            4'h4: return 8'h66;
            4'h5: return 8'h6d;
            4'h6: return 8'h7d;
            4'h7: return 8'h07;
            4'h8: return 8'h7f;
            4'h9: return 8'h6f;
            4'ha: return 8'h77;
            4'hb: return 8'h7c;
            4'hc: return 8'h39;
            4'hd: return 8'h5e;
            4'he: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

endpackage

/* logic/tm1638_display_driver.sv */
`timescale 1ns/10ps

module tm1638_display_driver
#(
    parameter sio_div = 32
)
(
    input                          clk,
    input                          rst_n,
    input  seg_pkg::panel_image_t  image,
    output logic                   sio_clk,
    output logic                   sio_stb,
    output logic                   sio_data
);

    import seg_pkg::*;

    localparam int         w_div       = (sio_div > 1) ? $clog2 (sio_div) : 1;
    localparam logic [7:0] cmd_data    = 8'h40;  // Auto-increment write
    localparam logic [7:0] cmd_addr    = 8'hc0;  // Start at address 0
    localparam logic [7:0] cmd_display = 8'h8f;  // Display on, full bright

    typedef enum logic [2:0] { st_gap, st_stb, st_low, st_high, st_end } state_t;

    state_t             state;
    logic [w_div - 1:0] div_cnt;
    logic               tick;
    logic [        1:0] xfer;                    // 0 command, 1 data, 2 display on
    logic [        4:0] byte_cnt;
    logic [        2:0] bit_cnt;
    logic [        4:0] last_byte;
    logic [        7:0] cur_byte;
    logic [        7:0] next_byte;
    panel_image_t       img_q;

    // Address space alternates digit segments and LED bytes
    function automatic logic [7:0] frame_byte (input logic [1:0] x,
                                               input logic [4:0] idx,
                                               input panel_image_t img);
        logic [4:0] data_idx;
        logic [7:0] result;
        data_idx = idx - 5'd1;
        if (x == 2'd0)
            result = cmd_data;
        else if (x == 2'd2)
            result = cmd_display;
        else if (idx == 5'd0)
            result = cmd_addr;
        else if (!data_idx [0])
            result = img.digits [data_idx [3:1]];
        else
            result = {7'b0, img.leds [data_idx [3:1]]};
        return result;
    endfunction

    assign tick      = (div_cnt == w_div'(sio_div - 1));
    assign last_byte = (xfer == 2'd1) ? 5'd16 : 5'd0;
    assign cur_byte  = frame_byte (xfer, byte_cnt, img_q);
    assign next_byte = frame_byte (xfer, byte_cnt + 5'd1, img_q);

    // ----------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= st_gap;
            div_cnt  <= '0;
            xfer     <= 2'd0;
            byte_cnt <= '0;
            bit_cnt  <= '0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            sio_data <= 1'b0;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;

            if (tick)
            begin
                case (state)
                    st_gap:
                    begin
                        sio_stb <= 1'b0;
                        state   <= st_stb;
                    end
                    st_stb:
                    begin
                        sio_clk  <= 1'b0;
                        sio_data <= cur_byte [0];
                        state    <= st_low;
                    end
                    st_low:
                    begin
                        sio_clk <= 1'b1;             // Panel samples here
                        state   <= st_high;
                    end
                    st_high:
                    begin
                        if (bit_cnt != 3'd7)
                        begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            sio_clk  <= 1'b0;
                            sio_data <= cur_byte [bit_cnt + 3'd1];
                            state    <= st_low;
                        end
                        else if (byte_cnt != last_byte)
                        begin
                            bit_cnt  <= '0;
                            byte_cnt <= byte_cnt + 1'b1;
                            sio_clk  <= 1'b0;
                            sio_data <= next_byte [0];
                            state    <= st_low;
                        end
                        else
                        begin
                            bit_cnt <= '0;
                            state   <= st_end;
                        end
                    end
                    default:
                    begin
                        sio_stb  <= 1'b1;
                        byte_cnt <= '0;
                        xfer     <= (xfer == 2'd2) ? 2'd0 : xfer + 1'b1;
                        state    <= st_gap;
                    end
                endcase
            end
        end
    end

    // Snapshot taken once per frame so all 16 data bytes agree
    always_ff @(posedge clk)
        if (tick && (state == st_gap) && (xfer == 2'd0))
            img_q <= image;

    data_stable_clk_high : assert property (
        @(posedge clk) disable iff (!rst_n)
        (sio_clk && $past (sio_clk)) |-> $stable (sio_data));

endmodule

/* test/board_specific_top_tb.sv */
`timescale 1ns/10ps

module board_specific_top_tb;

    import panel_cfg_pkg::*;
    import seg_pkg::*;

    localparam int sck_div         = 2;
    localparam int sio_div         = 2;
    localparam int debounce_cycles = 8;
    localparam int max_steps       = 32;
    localparam int mic_timeout     = 1000;      // About four I2S frames
    localparam int frame_timeout   = 3000;      // About four panel frames
    localparam int led_timeout     = 20 * debounce_cycles;

    // Glyphs 0 to F with segment a in bit 0
    localparam seg_t glyphs [0:15] = '{
        8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
        8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71 };

    logic               clk = 1'b0;
    logic               rst_n;
    logic [w_key - 1:0] key;
    logic               sd = 1'b0;
    logic               sck;
    logic               ws;
    logic               lr;
    logic               sio_clk;
    logic               sio_stb;
    logic               sio_data;
    logic [w_led - 1:0] led;

    logic [23:0] steps [0:max_steps * 5 - 1];    // Five words per step
    int          errors;
    int          checks;
    logic        timed_out;
    logic [23:0] model_peak;
    logic        model_clip;
    logic        model_freeze;

    // Microphone model state
    logic [23:0] mic_word;
    int          words_queued;
    int          words_taken = 0;
    int          words_sent  = 0;
    logic [23:0] tx_word     = '0;
    logic        tx_active   = 1'b0;
    int          bit_idx     = 63;
    logic        sck_prev    = 1'b0;
    logic        ws_prev     = 1'b0;

    // TM1638 decoder state
    logic [7:0]  rx_shift     = '0;
    int          rx_bits      = 0;
    int          rx_count     = 0;
    int          byte_pos     = 0;
    int          xfer_idx     = 0;
    int          frame_starts = 0;
    int          frame_done   = 0;
    int          bad_frames   = 0;
    logic        stb_prev     = 1'b1;
    logic        sclk_prev    = 1'b1;
    logic [7:0]  work_bytes  [0:18];             // 40, C0, 16 data bytes, 8F
    logic [7:0]  frame_bytes [0:18];
    int          xfer_len    [0:2];
    int          frame_lens  [0:2];

    board_specific_top
    #(
        .clk_mhz         ( 125             ),
        .sck_div         ( sck_div         ),
        .sio_div         ( sio_div         ),
        .debounce_cycles ( debounce_cycles )
    )
    board_specific_top_i
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .key      ( key      ),
        .sd       ( sd       ),
        .sck      ( sck      ),
        .ws       ( ws       ),
        .lr       ( lr       ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data ),
        .led      ( led      )
    );

    always #4 clk = ~clk;

    //--------------------------------------------------------------------------
    // INMP441 model that puts out a new bit on each sck fall

    always @(posedge clk)
    begin
        #1;
        if (sck_prev && !sck)
        begin
            if (ws_prev && !ws)                  // Left slot begins
            begin
                bit_idx = 0;
                if (words_queued != words_taken)
                begin
                    tx_word     = mic_word;
                    tx_active   = 1'b1;
                    words_taken = words_queued;
                end
            end
            else if (bit_idx < 63)
                bit_idx++;

            if (tx_active && (bit_idx == 25))
            begin
                tx_active = 1'b0;
                words_sent++;
            end

            // One slot of delay and then MSB first
            sd = (tx_active && (bit_idx >= 1) && (bit_idx <= 24)) ? tx_word [24 - bit_idx] : 1'b0;
        end
        sck_prev = sck;
        ws_prev  = ws;
    end

    //--------------------------------------------------------------------------
    // TM1638 decoder that collects bytes between sio_stb edges

    always @(posedge clk)
    begin
        #1;
        if (stb_prev && !sio_stb)
        begin
            if (xfer_idx == 0)
            begin
                frame_starts++;
                byte_pos = 0;
            end
            rx_bits  = 0;
            rx_count = 0;
        end
        else if (!stb_prev && sio_stb)
        begin
            xfer_len [xfer_idx] = rx_count;
            if (xfer_idx == 2)
            begin
                if (xfer_len [0] !== 1 || xfer_len [1] !== 17 || xfer_len [2] !== 1
                    || work_bytes [0] !== 8'h40 || work_bytes [1] !== 8'hc0
                    || work_bytes [18] !== 8'h8f
                    || work_bytes [14] !== seg_blank || work_bytes [16] !== seg_blank)
                    bad_frames++;
                frame_bytes = work_bytes;
                frame_lens  = xfer_len;
                frame_done++;
            end
            xfer_idx = (xfer_idx + 1) % 3;
        end
        else if (!sclk_prev && sio_clk && !sio_stb)
        begin
            rx_shift = {sio_data, rx_shift [7:1]};    // LSB arrives first
            rx_bits++;
            if (rx_bits == 8)
            begin
                if (byte_pos < 19)
                    work_bytes [byte_pos] = rx_shift;
                byte_pos++;
                rx_count++;
                rx_bits = 0;
            end
        end
        stb_prev  = sio_stb;
        sclk_prev = sio_clk;
    end

    //--------------------------------------------------------------------------

    task automatic compare (input string name, input logic [31:0] got,
                            input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic next_cycle ();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [23:0] magnitude (input logic [23:0] v);
        if (!v [23])
            return v;
        if (v == 24'h800000)
            return 24'h7fffff;                   // Most negative value saturates
        return ~v + 24'd1;
    endfunction

    task automatic pulse_clear_key (input int low_cycles);
        key [0] = 1'b0;
        repeat (low_cycles) next_cycle ();
        key [0] = 1'b1;
        repeat (4 * debounce_cycles) next_cycle ();  // Let the release settle
    endtask

    task automatic set_freeze (input logic on);
        int n;
        key [1] = ~on;
        n = 0;
        while (led [0] !== on && n < led_timeout)
        begin
            next_cycle ();
            n++;
        end
        if (led [0] !== on)
        begin
            $display("Timeout: led[0] did not follow the freeze key within %0d cycles", n);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic send_sample (input logic [23:0] value);
        int sent0;
        int n;
        sent0    = words_sent;
        mic_word = value;
        words_queued++;
        n = 0;
        while (words_sent == sent0 && n < mic_timeout)
        begin
            next_cycle ();
            n++;
        end
        if (words_sent == sent0)
        begin
            $display("Timeout: the microphone model sent no word within %0d cycles", n);
            errors++;
            timed_out = 1'b1;
        end
        else
            repeat (4) next_cycle ();            // Valid plus one meter clock
    endtask

    task automatic wait_frame ();
        int target;
        int n;
        target = frame_starts + 1;               // First frame to latch the new image
        n = 0;
        while (frame_done < target && n < frame_timeout)
        begin
            next_cycle ();
            n++;
        end
        if (frame_done < target)
        begin
            $display("Timeout: no complete TM1638 frame within %0d cycles", n);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_display (input logic [23:0] peak, input logic clip,
                                  input logic freeze);
        int   d;
        seg_t exp_digit;
        compare("transfer 1 length", frame_lens [0], 1);
        compare("transfer 2 length", frame_lens [1], 17);
        compare("transfer 3 length", frame_lens [2], 1);
        compare("command byte", 32'(frame_bytes [0]), 32'h40);
        compare("address byte", 32'(frame_bytes [1]), 32'hc0);
        compare("display byte", 32'(frame_bytes [18]), 32'h8f);
        for (d = 0; d < w_tm_digit; d++)
        begin
            if (d < 6)
                exp_digit = glyphs [peak [d * 4 +: 4]];
            else
                exp_digit = seg_blank;
            compare($sformatf("digit %0d", d), 32'(frame_bytes [2 + 2 * d]), 32'(exp_digit));
            compare($sformatf("panel led %0d", d), 32'(frame_bytes [3 + 2 * d]),
                    32'(peak [22:20] > 3'(d)));
        end
        compare("led[0]", 32'(led [0]), 32'(freeze));
        compare("led[1]", 32'(led [1]), 32'(clip));
        compare("lr", 32'(lr), 32'h0);
    endtask

    task automatic run_step (input int k);
        logic [23:0] sample;
        logic [3:0]  action;
        logic [23:0] mag;
        sample = steps [5 * k];
        action = steps [5 * k + 1][3:0];
        case (action)
            4'h1:
            begin
                pulse_clear_key (4 * debounce_cycles);
                model_peak = '0;
                model_clip = 1'b0;
            end
            4'h2: pulse_clear_key (debounce_cycles - 3);   // Too short to pass
            4'h3: set_freeze (1'b1);
            4'h4: set_freeze (1'b0);
            default: ;
        endcase
        if (action == 4'h3)
            model_freeze = 1'b1;
        else if (action == 4'h4)
            model_freeze = 1'b0;
        if (timed_out)
            return;

        mag = magnitude (sample);
        if (mag >= clip_level)
            model_clip = 1'b1;
        if (!model_freeze && mag > model_peak)
            model_peak = mag;
        compare("file peak", 32'(steps [5 * k + 2]), 32'(model_peak));
        compare("file clip", 32'(steps [5 * k + 3]), 32'(model_clip));
        compare("file freeze", 32'(steps [5 * k + 4]), 32'(model_freeze));

        send_sample (sample);
        if (!timed_out)
            wait_frame ();
        if (!timed_out)
            check_display (steps [5 * k + 2], steps [5 * k + 3][0], steps [5 * k + 4][0]);
    endtask

    //--------------------------------------------------------------------------

    initial
    begin
        int   k;
        logic finished;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        rst_n        = 1'b0;
        key          = '1;                       // Keys released and active low
        mic_word     = '0;
        words_queued = 0;
        model_peak   = '0;
        model_clip   = 1'b0;
        model_freeze = 1'b0;
        $readmemh("test/mic_testdata.txt", steps);

        repeat (10) next_cycle ();
        rst_n = 1'b1;

        k        = 0;
        finished = 1'b0;
        while (!finished)
        begin
            if (k >= max_steps || $isunknown(steps [5 * k + 1]))
            begin
                $display("Test data ended without an end marker after %0d steps", k);
                errors++;
                finished = 1'b1;
            end
            else if (steps [5 * k + 1] == 24'hf)
                finished = 1'b1;
            else
            begin
                run_step (k);
                k++;
                finished = timed_out;
            end
        end
        compare("malformed frames", bad_frames, 0);

        $display("Steps: %0d, checks: %0d, errors: %0d", k, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* test/mic_testdata.txt */
// Columns in hex: left sample, key action, expected peak, expected clip, expected freeze
// Key action: 0 none, 1 clear press, 2 short clear glitch, 3 freeze on, 4 freeze off, f end
000123 0 000123 0 0
fff000 0 001000 0 0
000800 0 001000 0 0
000000 2 001000 0 0
234567 0 234567 0 0
000000 1 000000 0 0
100000 3 000000 0 1
7fffff 0 000000 1 1
100000 4 100000 1 0
800000 0 7fffff 1 0
000010 0 7fffff 1 0
000000 1 000000 0 0
7fefff 0 7fefff 0 0
7ff000 0 7ff000 1 0
f00000 0 7ff000 1 0
000000 f 000000 0 0
